/* files.f */
hdl/icache_pkg.sv
hdl/fetch_if.sv
hdl/fetch_port.sv
hdl/i_cache.sv
hdl/mem_read_master.sv
hdl/icache_subsystem.sv
testbench/icache_properties.sv
testbench/tb_icache_subsystem.sv

/* hdl/fetch_if.sv */
`default_nettype none

// One fetch request and its response between two stages
interface fetch_if import icache_pkg::*; ();

    // Request half
    logic [ADDR_WIDTH-1:0] req_addr;
    logic                  req_valid;
    logic                  req_ready;

    // Response half
    logic [DATA_WIDTH-1:0] rsp_data;
    logic                  rsp_err;
    logic                  rsp_valid;
    logic                  rsp_ready;

    // Side that issues the fetch and takes the word back
    modport requester (
        output req_addr,
        output req_valid,
        input  req_ready,
        input  rsp_data,
        input  rsp_err,
        input  rsp_valid,
        output rsp_ready
    );

    // Side that serves the fetch
    modport responder (
        input  req_addr,
        input  req_valid,
        output req_ready,
        output rsp_data,
        output rsp_err,
        output rsp_valid,
        input  rsp_ready
    );

endinterface

`default_nettype wire

/* hdl/fetch_port.sv */
`default_nettype none

module fetch_port import icache_pkg::*; (
    input  wire                   clk,
    input  wire                   clrn,

    // AXI4-Lite read slave towards the processor
    input  wire  [ADDR_WIDTH-1:0] s_araddr,
    input  wire                   s_arvalid,
    output logic                  s_arready,
    output logic [DATA_WIDTH-1:0] s_rdata,
    output logic [RESP_WIDTH-1:0] s_rresp,
    output logic                  s_rvalid,
    input  wire                   s_rready,

    fetch_if.requester            cpu
);

    logic [ADDR_WIDTH-1:0] addr_q;
    logic                  addr_full;
    logic                  ar_hs;
    logic                  req_xfer;
    logic                  rsp_xfer;
    logic                  r_hs;

    assign ar_hs    = s_arvalid && s_arready;
    assign req_xfer = cpu.req_valid && cpu.req_ready;
    assign rsp_xfer = cpu.rsp_valid && cpu.rsp_ready;
    assign r_hs     = s_rvalid && s_rready;

    ////////////////////////////////////////////////////////////
    // Address side
    ////////////////////////////////////////////////////////////

    assign cpu.req_addr  = addr_q;
    assign cpu.req_valid = addr_full;

    // Ready tracks an empty address register, low while in reset
    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            addr_full <= 1'b0;
            s_arready <= 1'b0;
        end else begin
            if (ar_hs) begin
                addr_full <= 1'b1;
            end else if (req_xfer) begin
                addr_full <= 1'b0;
            end
            s_arready <= !(ar_hs || (addr_full && !req_xfer));
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q <= s_araddr;
        end
    end

    ////////////////////////////////////////////////////////////
    // Response side
    ////////////////////////////////////////////////////////////

    // A pending R beat blocks the next response from the cache
    assign cpu.rsp_ready = !s_rvalid;

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            s_rvalid <= 1'b0;
        end else if (rsp_xfer) begin
            s_rvalid <= 1'b1;
        end else if (r_hs) begin
            s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_xfer) begin
            s_rdata <= cpu.rsp_data;
            s_rresp <= cpu.rsp_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

/* hdl/i_cache.sv */
`default_nettype none

module i_cache import icache_pkg::*; (
    input  wire        clk,
    input  wire        clrn,
    input  wire        flush,
    output logic       lookup_miss,

    fetch_if.responder cpu,
    fetch_if.requester mem
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HIT_RSP,
        ST_MISS_REQ,
        ST_MISS_WAIT,
        ST_FILL_RSP
    } state_t;

    state_t state;

    // Line storage
    logic [LINE_COUNT-1:0] valid_q;
    logic [TAG_WIDTH-1:0]  tag_mem  [LINE_COUNT];
    logic [DATA_WIDTH-1:0] data_mem [LINE_COUNT];

    // Word-aligned address of the fetch in progress
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0] rsp_data_q;
    logic                  rsp_err_q;

    logic [INDEX_WIDTH-1:0] req_index;
    logic [TAG_WIDTH-1:0]   req_tag;
    logic [INDEX_WIDTH-1:0] fill_index;
    logic [TAG_WIDTH-1:0]   fill_tag;
    logic                   lookup_hit;
    logic                   req_xfer;
    logic                   mem_rsp_xfer;
    logic                   fill_en;

    ////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////

    assign req_index  = cpu.req_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_tag    = cpu.req_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign lookup_hit = valid_q[req_index] && (tag_mem[req_index] == req_tag);

    assign fill_index = addr_q[OFFSET_WIDTH +: INDEX_WIDTH];
    assign fill_tag   = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];

    assign req_xfer     = cpu.req_valid && cpu.req_ready;
    assign mem_rsp_xfer = mem.rsp_valid && mem.rsp_ready;

    // Error words are never stored, and flush wins over a fill
    assign fill_en = mem_rsp_xfer && !mem.rsp_err && !flush;

    // Stage handshakes
    assign cpu.req_ready = (state == ST_IDLE);
    assign cpu.rsp_valid = (state == ST_HIT_RSP) || (state == ST_FILL_RSP);
    assign cpu.rsp_data  = rsp_data_q;
    assign cpu.rsp_err   = rsp_err_q;

    assign mem.req_addr  = addr_q;
    assign mem.req_valid = (state == ST_MISS_REQ);
    assign mem.rsp_ready = (state == ST_MISS_WAIT);

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            state       <= ST_IDLE;
            lookup_miss <= 1'b0;
        end else begin
            lookup_miss <= req_xfer && !lookup_hit;
            case (state)
                ST_IDLE: begin
                    if (req_xfer) begin
                        state <= lookup_hit ? ST_HIT_RSP : ST_MISS_REQ;
                    end
                end
                ST_MISS_REQ: begin
                    if (mem.req_ready) begin
                        state <= ST_MISS_WAIT;
                    end
                end
                ST_MISS_WAIT: begin
                    if (mem_rsp_xfer) begin
                        state <= ST_FILL_RSP;
                    end
                end
                ST_HIT_RSP, ST_FILL_RSP: begin
                    if (cpu.rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Payload of the fetch in progress
    always_ff @(posedge clk) begin
        if (req_xfer) begin
            addr_q     <= {cpu.req_addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
            rsp_data_q <= data_mem[req_index];
            rsp_err_q  <= 1'b0;
        end else if (mem_rsp_xfer) begin
            rsp_data_q <= mem.rsp_data;
            rsp_err_q  <= mem.rsp_err;
        end
    end

    ////////////////////////////////////////////////////////////
    // Arrays
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= mem.rsp_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////

    // Byte address and instruction word
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // AXI response field
    localparam int RESP_WIDTH = 2;

    ////////////////////////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////////////////////////

    // One word per line, so the byte offset is just the low two bits
    localparam int OFFSET_WIDTH = 2;
    localparam int INDEX_WIDTH  = 6;
    localparam int LINE_COUNT   = 1 << INDEX_WIDTH;
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    ////////////////////////////////////////////////////////////
    // AXI response codes
    ////////////////////////////////////////////////////////////

    localparam logic [RESP_WIDTH-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_WIDTH-1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* hdl/icache_subsystem.sv */
`default_nettype none

module icache_subsystem import icache_pkg::*; (
    input  wire                  clk,
    input  wire                  clrn,
    input  wire                  flush,
    output wire                  lookup_miss,

    // Processor read channel
    input  wire [ADDR_WIDTH-1:0] s_araddr,
    input  wire                  s_arvalid,
    output wire                  s_arready,
    output wire [DATA_WIDTH-1:0] s_rdata,
    output wire [RESP_WIDTH-1:0] s_rresp,
    output wire                  s_rvalid,
    input  wire                  s_rready,

    // Memory read channel
    output wire [ADDR_WIDTH-1:0] m_araddr,
    output wire                  m_arvalid,
    input  wire                  m_arready,
    input  wire [DATA_WIDTH-1:0] m_rdata,
    input  wire [RESP_WIDTH-1:0] m_rresp,
    input  wire                  m_rvalid,
    output wire                  m_rready
);

    ////////////////////////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////////////////////////

    // Port to cache, then cache to memory master
    fetch_if cpu_req ();
    fetch_if mem_req ();

    ////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////

    fetch_port fetch_port_i (
        .clk       (clk),
        .clrn      (clrn),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .cpu       (cpu_req.requester)
    );

    i_cache i_cache_i (
        .clk         (clk),
        .clrn        (clrn),
        .flush       (flush),
        .lookup_miss (lookup_miss),
        .cpu         (cpu_req.responder),
        .mem         (mem_req.requester)
    );

    mem_read_master mem_read_master_i (
        .clk       (clk),
        .clrn      (clrn),
        .m_araddr  (m_araddr),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_rdata   (m_rdata),
        .m_rresp   (m_rresp),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready),
        .mem       (mem_req.responder)
    );

endmodule

`default_nettype wire

/* hdl/mem_read_master.sv */
`default_nettype none

module mem_read_master import icache_pkg::*; (
    input  wire                   clk,
    input  wire                   clrn,

    // AXI4-Lite read master towards backing memory
    output logic [ADDR_WIDTH-1:0] m_araddr,
    output logic                  m_arvalid,
    input  wire                   m_arready,
    input  wire  [DATA_WIDTH-1:0] m_rdata,
    input  wire  [RESP_WIDTH-1:0] m_rresp,
    input  wire                   m_rvalid,
    output logic                  m_rready,

    fetch_if.responder            mem
);

    logic [DATA_WIDTH-1:0] rsp_data_q;
    logic                  rsp_err_q;
    logic                  rsp_valid_q;
    logic                  req_xfer;
    logic                  rsp_xfer;
    logic                  ar_hs;
    logic                  r_hs;

    assign req_xfer = mem.req_valid && mem.req_ready;
    assign rsp_xfer = mem.rsp_valid && mem.rsp_ready;
    assign ar_hs    = m_arvalid && m_arready;
    assign r_hs     = m_rvalid && m_rready;

    // Busy from request acceptance until the word is handed back
    assign mem.req_ready = !(m_arvalid || m_rready || rsp_valid_q);
    assign mem.rsp_valid = rsp_valid_q;
    assign mem.rsp_data  = rsp_data_q;
    assign mem.rsp_err   = rsp_err_q;

    ////////////////////////////////////////////////////////////
    // Read sequence
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            m_arvalid   <= 1'b0;
            m_rready    <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            if (req_xfer) begin
                m_arvalid <= 1'b1;
            end else if (ar_hs) begin
                m_arvalid <= 1'b0;
            end

            // R channel open only while the read is outstanding
            if (ar_hs) begin
                m_rready <= 1'b1;
            end else if (r_hs) begin
                m_rready <= 1'b0;
            end

            if (r_hs) begin
                rsp_valid_q <= 1'b1;
            end else if (rsp_xfer) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_xfer) begin
            m_araddr <= mem.req_addr;
        end
        if (r_hs) begin
            rsp_data_q <= m_rdata;
            // DECERR counts as a failure too
            rsp_err_q  <= (m_rresp != RESP_OKAY);
        end
    end

endmodule

`default_nettype wire

/* testbench/icache_properties.sv */
`default_nettype none

module icache_properties import icache_pkg::*; (
    input wire                  clk,
    input wire                  clrn,
    input wire [ADDR_WIDTH-1:0] m_araddr,
    input wire                  m_arvalid,
    input wire                  m_arready,
    input wire                  m_rvalid,
    input wire                  m_rready,
    input wire [DATA_WIDTH-1:0] s_rdata,
    input wire [RESP_WIDTH-1:0] s_rresp,
    input wire                  s_rvalid,
    input wire                  s_rready
);

    int unsigned failures = 0;
    logic        read_open;

    // Memory read in flight from AR handshake to R handshake
    always_ff @(posedge clk or negedge clrn) begin
        if (!clrn) begin
            read_open <= 1'b0;
        end else if (m_arvalid && m_arready) begin
            read_open <= 1'b1;
        end else if (m_rvalid && m_rready) begin
            read_open <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Handshake rules
    ////////////////////////////////////////////////////////////

    s_r_held: assert property (@(posedge clk) disable iff (!clrn)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp))
        else begin
            failures++;
            $error("s_rvalid or its payload changed before the R handshake");
        end

    m_ar_held: assert property (@(posedge clk) disable iff (!clrn)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
        else begin
            failures++;
            $error("m_arvalid or m_araddr changed before the AR handshake");
        end

    // Low on the first edge out of reset
    m_ar_reset_low: assert property (@(posedge clk) !clrn |=> !m_arvalid)
        else begin
            failures++;
            $error("m_arvalid high right after reset");
        end

    m_ar_single: assert property (@(posedge clk) disable iff (!clrn)
        read_open |-> !$rose(m_arvalid))
        else begin
            failures++;
            $error("m_arvalid rose while a memory read was outstanding");
        end

endmodule

bind icache_subsystem icache_properties properties_i (
    .clk       (clk),
    .clrn      (clrn),
    .m_araddr  (m_araddr),
    .m_arvalid (m_arvalid),
    .m_arready (m_arready),
    .m_rvalid  (m_rvalid),
    .m_rready  (m_rready),
    .s_rdata   (s_rdata),
    .s_rresp   (s_rresp),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready)
);

`default_nettype wire

/* testbench/tb_icache_subsystem.sv */
`default_nettype none

module tb_icache_subsystem import icache_pkg::*; ();

    localparam logic [31:0]          SEED           = 32'h00a8f585;
    localparam logic [DATA_WIDTH-1:0] MEM_XOR        = 32'h5a3c_9e01;
    localparam int unsigned          FETCH_COUNT    = 400;
    localparam int unsigned          TIMEOUT_CYCLES = 200;

    logic                  clk = 1'b0;
    logic                  clrn;
    logic                  flush;
    wire                   lookup_miss;
    logic [ADDR_WIDTH-1:0] s_araddr;
    logic                  s_arvalid;
    wire                   s_arready;
    wire  [DATA_WIDTH-1:0] s_rdata;
    wire  [RESP_WIDTH-1:0] s_rresp;
    wire                   s_rvalid;
    logic                  s_rready;
    wire  [ADDR_WIDTH-1:0] m_araddr;
    wire                   m_arvalid;
    logic                  m_arready;
    logic [DATA_WIDTH-1:0] m_rdata;
    logic [RESP_WIDTH-1:0] m_rresp;
    logic                  m_rvalid;
    wire                   m_rready;

    // Memory responder state
    logic                  mem_busy;
    logic [ADDR_WIDTH-1:0] mem_addr;
    int unsigned           ar_wait = 0;
    int unsigned           r_wait = 0;
    int unsigned           read_count = 0;
    int unsigned           miss_pulses = 0;
    int unsigned           resp_count = 0;

    // Reference cache and run statistics
    logic                  model_valid   [LINE_COUNT];
    logic [TAG_WIDTH-1:0]  model_tag     [LINE_COUNT];
    logic                  model_flushed [LINE_COUNT];
    logic [ADDR_WIDTH-1:0] addr_pool     [8];
    int unsigned           req_count = 0;
    int unsigned           hit_count = 0;
    int unsigned           conflict_count = 0;
    int unsigned           error_count = 0;
    int unsigned           flush_miss_count = 0;

    icache_subsystem icache_subsystem_i (
        .clk         (clk),
        .clrn        (clrn),
        .flush       (flush),
        .lookup_miss (lookup_miss),
        .s_araddr    (s_araddr),
        .s_arvalid   (s_arvalid),
        .s_arready   (s_arready),
        .s_rdata     (s_rdata),
        .s_rresp     (s_rresp),
        .s_rvalid    (s_rvalid),
        .s_rready    (s_rready),
        .m_araddr    (m_araddr),
        .m_arvalid   (m_arvalid),
        .m_arready   (m_arready),
        .m_rdata     (m_rdata),
        .m_rresp     (m_rresp),
        .m_rvalid    (m_rvalid),
        .m_rready    (m_rready)
    );

    always #10 clk = ~clk;

    // Backing memory word is its word address mixed with a constant
    function automatic logic [DATA_WIDTH-1:0] memory_word(input logic [ADDR_WIDTH-1:0] addr);
        return {2'b00, addr[ADDR_WIDTH-1:2]} ^ MEM_XOR;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, expected);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    ////////////////////////////////////////////////////////////
    // Memory responder and monitors
    ////////////////////////////////////////////////////////////

    initial begin : memory_responder
        m_arready <= 1'b0;
        m_rvalid  <= 1'b0;
        m_rdata   <= '0;
        m_rresp   <= RESP_OKAY;
        forever begin
            @(posedge clk);
            if (!clrn) begin
                m_arready <= 1'b0;
                m_rvalid  <= 1'b0;
                mem_busy  <= 1'b0;
            end else if (m_rvalid) begin
                if (m_rready) begin
                    m_rvalid <= 1'b0;
                end
            end else if (mem_busy) begin
                if (r_wait == 0) begin
                    m_rvalid <= 1'b1;
                    m_rdata  <= memory_word(mem_addr);
                    // Upper half of the address space answers with an error
                    m_rresp  <= mem_addr[ADDR_WIDTH-1] ? RESP_SLVERR : RESP_OKAY;
                    mem_busy <= 1'b0;
                end else begin
                    r_wait <= r_wait - 1;
                end
            end else if (m_arvalid && m_arready) begin
                m_arready  <= 1'b0;
                mem_busy   <= 1'b1;
                mem_addr   <= m_araddr;
                r_wait     <= $urandom_range(0, 5);
                read_count <= read_count + 1;
            end else if (m_arvalid) begin
                if (ar_wait == 0) begin
                    m_arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end else begin
                ar_wait <= $urandom_range(0, 3);
            end
        end
    end

    always @(posedge clk) begin
        if (clrn && lookup_miss) begin
            miss_pulses <= miss_pulses + 1;
        end
        if (clrn && s_rvalid && s_rready) begin
            resp_count <= resp_count + 1;
        end
    end

    // A failed handshake property ends the run at once
    always @(posedge clk) begin
        assert (icache_subsystem_i.properties_i.failures == 0)
            else report_failure("a handshake property failed");
    end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic pulse_flush();
        int unsigned k;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (k = 0; k < LINE_COUNT; k++) begin
            model_flushed[k] = model_flushed[k] || model_valid[k];
            model_valid[k]   = 1'b0;
        end
    endtask

    // One fetch from AR handshake to R handshake checked against the model
    task automatic run_fetch(input logic [ADDR_WIDTH-1:0] addr);
        logic [INDEX_WIDTH-1:0] idx;
        logic [TAG_WIDTH-1:0]   tag;
        logic                   exp_hit;
        logic                   exp_err;
        logic [DATA_WIDTH-1:0]  held_data;
        logic [RESP_WIDTH-1:0]  held_resp;
        logic                   seen;
        logic                   done;
        int unsigned            reads_before;
        int unsigned            pulses_before;
        int unsigned            waited;
        int unsigned            rise_at;

        idx           = addr[OFFSET_WIDTH +: INDEX_WIDTH];
        tag           = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
        exp_hit       = model_valid[idx] && (model_tag[idx] == tag);
        exp_err       = addr[ADDR_WIDTH-1];
        reads_before  = read_count;
        pulses_before = miss_pulses;

        @(posedge clk);
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        waited = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (s_arready) begin
                done = 1'b1;
            end else begin
                waited++;
                assert (waited < TIMEOUT_CYCLES)
                    else report_failure("timeout waiting for s_arready");
            end
        end
        s_arvalid <= 1'b0;

        // Edges are counted from the AR handshake edge
        waited  = 0;
        seen    = 1'b0;
        done    = 1'b0;
        rise_at = 0;
        while (!done) begin
            @(posedge clk);
            waited++;
            if (s_rvalid) begin
                if (!seen) begin
                    seen      = 1'b1;
                    rise_at   = waited;
                    held_data = s_rdata;
                    held_resp = s_rresp;
                end else begin
                    assert (s_rdata == held_data)
                        else report_mismatch("s_rdata", s_rdata, held_data);
                    assert (s_rresp == held_resp)
                        else report_mismatch("s_rresp", 32'(s_rresp), 32'(held_resp));
                end
                done = s_rready;
            end
            if (!done) begin
                assert (waited < TIMEOUT_CYCLES)
                    else report_failure("timeout waiting for the R handshake");
            end
            s_rready <= ($urandom_range(0, 3) != 0);
        end

        assert (s_rdata == memory_word(addr))
            else report_mismatch("s_rdata", s_rdata, memory_word(addr));
        assert (s_rresp == (exp_err ? RESP_SLVERR : RESP_OKAY))
            else report_mismatch("s_rresp", 32'(s_rresp), exp_err ? 32'd2 : 32'd0);

        if (exp_hit) begin
            assert (rise_at == 3) else report_mismatch("s_rvalid latency", rise_at, 32'd3);
            assert (read_count == reads_before)
                else report_mismatch("memory read count", read_count, reads_before);
            assert (miss_pulses == pulses_before)
                else report_mismatch("lookup_miss pulses", miss_pulses, pulses_before);
            hit_count++;
        end else begin
            assert (read_count == reads_before + 1)
                else report_mismatch("memory read count", read_count, reads_before + 1);
            assert (miss_pulses == pulses_before + 1)
                else report_mismatch("lookup_miss pulses", miss_pulses, pulses_before + 1);
            assert (mem_addr == {addr[ADDR_WIDTH-1:OFFSET_WIDTH], 2'b00})
                else report_mismatch("m_araddr", mem_addr,
                                     {addr[ADDR_WIDTH-1:OFFSET_WIDTH], 2'b00});
            if (model_valid[idx]) begin
                conflict_count++;
            end
            if (model_flushed[idx] && (model_tag[idx] == tag)) begin
                flush_miss_count++;
            end
            model_flushed[idx] = 1'b0;
            if (!exp_err) begin
                model_valid[idx] = 1'b1;
                model_tag[idx]   = tag;
            end
        end
        if (exp_err) begin
            error_count++;
        end
        req_count++;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        int unsigned k;
        int unsigned n;
        logic [TAG_WIDTH-1:0] tags [4];

        void'($urandom(SEED));
        clrn      <= 1'b0;
        flush     <= 1'b0;
        s_araddr  <= '0;
        s_arvalid <= 1'b0;
        s_rready  <= 1'b0;
        for (k = 0; k < LINE_COUNT; k++) begin
            model_valid[k]   = 1'b0;
            model_tag[k]     = '0;
            model_flushed[k] = 1'b0;
        end

        // Few indexes and several tags with one tag in the error region
        tags[0] = 24'h000010;
        tags[1] = 24'h000abc;
        tags[2] = 24'h800010;
        tags[3] = 24'h3c5a00;
        for (k = 0; k < 8; k++) begin
            addr_pool[k] = {tags[k % 4], 8'h00} | ((k % 3) << 2);
        end

        repeat (8) @(posedge clk);
        clrn <= 1'b1;
        repeat (2) @(posedge clk);

        for (n = 0; n < FETCH_COUNT; n++) begin
            run_fetch(addr_pool[$urandom_range(0, 7)] | ($urandom() & 32'h3));
            if ($urandom_range(0, 11) == 0) begin
                pulse_flush();
            end
            repeat ($urandom_range(0, 2)) @(posedge clk);
        end
        repeat (4) @(posedge clk);

        assert (resp_count == req_count)
            else report_mismatch("response count", resp_count, req_count);
        assert (hit_count > 0) else report_failure("no cache hit was exercised");
        assert (conflict_count > 0) else report_failure("no index conflict was exercised");
        assert (error_count > 0) else report_failure("no error response was exercised");
        assert (flush_miss_count > 0) else report_failure("no miss after flush was exercised");

        if (icache_subsystem_i.properties_i.failures == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("ERROR: %0d handshake property failures",
                     icache_subsystem_i.properties_i.failures);
            $display("Simulation failed");
            $fatal(1, "handshake properties failed");
        end
    end

endmodule

`default_nettype wire
